/* common/loader_cfg.svh */
/*
 * file-download loader configuration
 * widths, download indices, address limits and BASIC pointer addresses
 */
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// bus widths
`define LDR_IOCTL_AW 25
`define LDR_AW 16
`define LDR_DW 8

// download indices from the host menu
`define LDR_IDX_PRG 8'h01
`define LDR_IDX_CRT 8'h41
`define LDR_IDX_CT 8'h81
`define LDR_IDX_ROM 8'h06
// megacart matches on the low five index bits only
`define LDR_IDX_MC_LOW 8'h02

// address limits and kernal window
`define LDR_PRG_LIMIT 16'hA000
`define LDR_CART_LIMIT 16'hC000
`define LDR_ROM_FIRST 16'h4000
`define LDR_ROM_END 16'h8000
`define LDR_ROM_OFFSET 16'h8000

// one flag per 8k cartridge block: blk0..3 and blk5
`define LDR_NBLK 5

// BASIC pointers patched after a program load, low/high pairs
`define LDR_PTR_COUNT 8
`define LDR_PTR_ADDR_0 16'h002D
`define LDR_PTR_ADDR_1 16'h002E
`define LDR_PTR_ADDR_2 16'h002F
`define LDR_PTR_ADDR_3 16'h0030
`define LDR_PTR_ADDR_4 16'h0031
`define LDR_PTR_ADDR_5 16'h0032
`define LDR_PTR_ADDR_6 16'h00AE
`define LDR_PTR_ADDR_7 16'h00AF

`endif

/* common/loader_pkg.sv */
/*
 * loader types
 * download kinds and the pointer fixup FSM states
 */
package loader_pkg;

	////////////////////
	// download kinds
	////////////////////

	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_PRG  = 3'd1,
		LOAD_CRT  = 3'd2,
		LOAD_CT   = 3'd3,
		LOAD_ROM  = 3'd4,
		LOAD_MC   = 3'd5
	} load_kind_t;

	////////////////////
	// fixup FSM states
	////////////////////

	typedef enum logic [1:0] {
		FIX_IDLE  = 2'd0,
		FIX_WRITE = 2'd1,
		FIX_GAP   = 2'd2
	} fixup_state_t;

endpackage

/* loader/load_decode.sv */
/*
 * loader stage 1: classifies the download, registers the host byte
 * stream, makes start/end strobes and the raw-cart start address
 */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module load_decode import loader_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     i_ioctl_download,
	input  logic [7:0]               i_ioctl_index,
	input  logic                     i_ioctl_wr,
	input  logic [`LDR_IOCTL_AW-1:0] i_ioctl_addr,
	input  logic [`LDR_DW-1:0]       i_ioctl_dout,
	input  logic [7:0]               i_ext_char,
	output load_kind_t               o_kind,
	output logic                     o_wr,
	output logic [`LDR_IOCTL_AW-1:0] o_addr,
	output logic [`LDR_DW-1:0]       o_data,
	output logic                     o_start,
	output logic                     o_end,
	output logic                     o_active,
	output logic [`LDR_AW-1:0]       o_ct_base
);

	load_kind_t kind_d;
	logic [`LDR_AW-1:0] ct_base_d;

	// exact index first, megacart by low bits last
	always_comb begin
		if (i_ioctl_index == `LDR_IDX_PRG) kind_d = LOAD_PRG;
		else if (i_ioctl_index == `LDR_IDX_CRT) kind_d = LOAD_CRT;
		else if (i_ioctl_index == `LDR_IDX_CT) kind_d = LOAD_CT;
		else if (i_ioctl_index == `LDR_IDX_ROM) kind_d = LOAD_ROM;
		else if ({3'b000, i_ioctl_index[4:0]} == `LDR_IDX_MC_LOW) kind_d = LOAD_MC;
		else kind_d = LOAD_NONE;
	end

	// raw cart start from last extension char '2'..'9' or 'A'..'B'
	always_comb begin
		ct_base_d = '0;
		if (i_ext_char >= "2" && i_ext_char <= "9")
			ct_base_d = {i_ext_char[3:0], 12'h000};
		else if (i_ext_char >= "A" && i_ext_char <= "B")
			ct_base_d = {i_ext_char[3:0] + 4'd9, 12'h000};
	end

	// kind only tracks the index while download is high
	// so it is still valid in the end strobe cycle
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			o_kind   <= LOAD_NONE;
			o_wr     <= 1'b0;
			o_start  <= 1'b0;
			o_end    <= 1'b0;
			o_active <= 1'b0;
		end else begin
			if (i_ioctl_download) o_kind <= kind_d;
			o_wr     <= i_ioctl_wr;
			// o_active doubles as the previous level for edge detect
			o_start  <= i_ioctl_download & ~o_active;
			o_end    <= ~i_ioctl_download & o_active;
			o_active <= i_ioctl_download;
		end
	end

	// payload copy of the stream
	always_ff @(posedge clk_sys) begin
		o_addr    <= i_ioctl_addr;
		o_data    <= i_ioctl_dout;
		o_ct_base <= ct_base_d;
	end

endmodule

/* loader/load_address.sv */
/*
 * loader stage 2: running write address, limits and kernal remap,
 * cartridge block flags, cart-reset and megacart levels
 */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module load_address import loader_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     i_detach,
	input  load_kind_t               i_kind,
	input  logic                     i_wr,
	input  logic [`LDR_IOCTL_AW-1:0] i_addr,
	input  logic [`LDR_DW-1:0]       i_data,
	input  logic                     i_start,
	input  logic                     i_end,
	input  logic                     i_active,
	input  logic [`LDR_AW-1:0]       i_ct_base,
	output logic                     o_wr,
	output logic [`LDR_AW-1:0]       o_addr,
	output logic [`LDR_DW-1:0]       o_data,
	output logic                     o_prg_done,
	output logic [`LDR_AW-1:0]       o_end_addr,
	output logic [`LDR_NBLK-1:0]     o_cart_blk,
	output logic                     o_cart_reset,
	output logic                     o_mc_loaded
);

	logic [`LDR_AW-1:0] run_addr;
	logic [`LDR_AW-1:0] limit;
	logic [`LDR_AW-1:0] rom_addr;
	logic [`LDR_NBLK-1:0] blk_hit;
	logic [`LDR_NBLK-1:0] blk_r;
	logic host_wr, has_hdr, hdr_lo, hdr_hi, run_kind, run_wr, cart_wr, rom_wr;
	logic is_cart, detach_q, cart_reset_r, mc_loaded_r;

	////////////////////
	// write qualify
	////////////////////

	assign host_wr  = i_wr & i_active;
	assign has_hdr  = (i_kind == LOAD_PRG) || (i_kind == LOAD_CRT);
	assign hdr_lo   = host_wr && has_hdr && (i_addr == 0);
	assign hdr_hi   = host_wr && has_hdr && (i_addr == 1);
	assign run_kind = has_hdr || (i_kind == LOAD_CT);
	assign limit    = (i_kind == LOAD_PRG) ? `LDR_PRG_LIMIT : `LDR_CART_LIMIT;
	// header bytes never reach memory
	assign run_wr   = host_wr && run_kind && !hdr_lo && !hdr_hi && (run_addr < limit);
	assign cart_wr  = run_wr && (i_kind != LOAD_PRG);
	assign is_cart  = (i_kind == LOAD_CRT) || (i_kind == LOAD_CT) || (i_kind == LOAD_MC);

	// kernal image offsets 0x4000..0x7fff move up to 0xc000
	assign rom_wr   = host_wr && (i_kind == LOAD_ROM) &&
		(i_addr >= `LDR_ROM_FIRST) && (i_addr < `LDR_ROM_END);
	assign rom_addr = i_addr[`LDR_AW-1:0] + `LDR_ROM_OFFSET;

	// block flag from addr[15:13]
	// block 4 has no flag and block 5 maps to flag 4
	always_comb begin
		blk_hit = '0;
		case (run_addr[15:13])
			3'd0, 3'd1, 3'd2, 3'd3: blk_hit[run_addr[14:13]] = 1'b1;
			3'd5: blk_hit[4] = 1'b1;
			default: ;
		endcase
	end

	assign o_end_addr = run_addr;

	////////////////////
	// stream
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			o_wr       <= 1'b0;
			o_prg_done <= 1'b0;
			run_addr   <= '0;
		end else begin
			o_wr       <= run_wr | rom_wr;
			o_prg_done <= i_end && (i_kind == LOAD_PRG);
			if (i_start && i_kind == LOAD_CT) run_addr <= i_ct_base;
			if (hdr_lo) run_addr[7:0] <= i_data;
			if (hdr_hi) run_addr[15:8] <= i_data;
			if (run_wr) run_addr <= run_addr + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (run_wr | rom_wr) begin
			o_addr <= rom_wr ? rom_addr : run_addr;
			o_data <= i_data;
		end
	end

	////////////////////
	// flags
	////////////////////

	// detach gets one extra stage to line up with decoded events
	// outputs get one more so flags land with the stream writes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			detach_q     <= 1'b0;
			blk_r        <= '0;
			cart_reset_r <= 1'b0;
			mc_loaded_r  <= 1'b0;
			o_cart_blk   <= '0;
			o_cart_reset <= 1'b0;
			o_mc_loaded  <= 1'b0;
		end else begin
			detach_q <= i_detach;
			if (cart_wr) blk_r <= blk_r | blk_hit;
			// hold the machine in reset while a cart is loading
			if ((i_start | i_end) && is_cart) cart_reset_r <= i_active;
			if (i_active && i_kind == LOAD_CRT) mc_loaded_r <= 1'b0;
			if (i_active && i_kind == LOAD_MC) begin
				mc_loaded_r <= 1'b1;
				blk_r       <= '0;
			end
			if (detach_q) begin
				blk_r        <= '0;
				cart_reset_r <= 1'b0;
				mc_loaded_r  <= 1'b0;
			end
			o_cart_blk   <= blk_r;
			o_cart_reset <= cart_reset_r;
			o_mc_loaded  <= mc_loaded_r;
		end
	end

endmodule

/* loader/basic_fixup.sv */
/*
 * loader stage 3: passes stream writes through and, after a program
 * load, writes the end address into the eight BASIC pointer bytes
 */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module basic_fixup import loader_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               i_wr,
	input  logic [`LDR_AW-1:0] i_addr,
	input  logic [`LDR_DW-1:0] i_data,
	input  logic               i_prg_done,
	input  logic [`LDR_AW-1:0] i_end_addr,
	output logic               o_dl_wr,
	output logic [`LDR_AW-1:0] o_dl_addr,
	output logic [`LDR_DW-1:0] o_dl_data
);

	fixup_state_t state;
	logic [2:0] ptr_idx;
	logic [`LDR_AW-1:0] ptr_addr;

	// pointer table with the low byte at even slots
	always_comb begin
		case (ptr_idx)
			3'd0: ptr_addr = `LDR_PTR_ADDR_0;
			3'd1: ptr_addr = `LDR_PTR_ADDR_1;
			3'd2: ptr_addr = `LDR_PTR_ADDR_2;
			3'd3: ptr_addr = `LDR_PTR_ADDR_3;
			3'd4: ptr_addr = `LDR_PTR_ADDR_4;
			3'd5: ptr_addr = `LDR_PTR_ADDR_5;
			3'd6: ptr_addr = `LDR_PTR_ADDR_6;
			default: ptr_addr = `LDR_PTR_ADDR_7;
		endcase
	end

	////////////////////
	// fixup FSM
	////////////////////

	// write/gap pairs give one pointer byte every second cycle
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= FIX_IDLE;
			ptr_idx <= '0;
			o_dl_wr <= 1'b0;
		end else begin
			o_dl_wr <= (state == FIX_WRITE) | i_wr;
			case (state)
				FIX_IDLE: begin
					if (i_prg_done) begin
						state   <= FIX_WRITE;
						ptr_idx <= '0;
					end
				end
				FIX_WRITE: state <= FIX_GAP;
				FIX_GAP: begin
					if (ptr_idx == 3'(`LDR_PTR_COUNT - 1)) begin
						state <= FIX_IDLE;
					end else begin
						state   <= FIX_WRITE;
						ptr_idx <= ptr_idx + 1'b1;
					end
				end
				default: state <= FIX_IDLE;
			endcase
		end
	end

	// the host is idle during fixup so no stream writes arrive
	always_ff @(posedge clk_sys) begin
		if (state == FIX_WRITE) begin
			o_dl_addr <= ptr_addr;
			o_dl_data <= ptr_idx[0] ? i_end_addr[15:8] : i_end_addr[7:0];
		end else if (i_wr) begin
			o_dl_addr <= i_addr;
			o_dl_data <= i_data;
		end
	end

endmodule

/* loader/loader_top.sv */
/*
 * file-download loader top
 * decode, address and fixup stages in a chain
 */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module loader_top import loader_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     i_ioctl_download,
	input  logic [7:0]               i_ioctl_index,
	input  logic                     i_ioctl_wr,
	input  logic [`LDR_IOCTL_AW-1:0] i_ioctl_addr,
	input  logic [`LDR_DW-1:0]       i_ioctl_dout,
	input  logic [7:0]               i_ext_char,
	input  logic                     i_detach,
	output logic                     o_dl_wr,
	output logic [`LDR_AW-1:0]       o_dl_addr,
	output logic [`LDR_DW-1:0]       o_dl_data,
	output logic [`LDR_NBLK-1:0]     o_cart_blk,
	output logic                     o_cart_reset,
	output logic                     o_mc_loaded
);

	// decode to address
	load_kind_t kind;
	logic dec_wr, dec_start, dec_end, dec_active;
	logic [`LDR_IOCTL_AW-1:0] dec_addr;
	logic [`LDR_DW-1:0] dec_data;
	logic [`LDR_AW-1:0] ct_base;

	// address to fixup
	logic adr_wr, prg_done;
	logic [`LDR_AW-1:0] adr_addr, end_addr;
	logic [`LDR_DW-1:0] adr_data;

	load_decode u_decode (
		.clk_sys(clk_sys), .reset(reset),
		.i_ioctl_download(i_ioctl_download), .i_ioctl_index(i_ioctl_index),
		.i_ioctl_wr(i_ioctl_wr), .i_ioctl_addr(i_ioctl_addr),
		.i_ioctl_dout(i_ioctl_dout), .i_ext_char(i_ext_char),
		.o_kind(kind), .o_wr(dec_wr), .o_addr(dec_addr), .o_data(dec_data),
		.o_start(dec_start), .o_end(dec_end), .o_active(dec_active),
		.o_ct_base(ct_base)
	);

	load_address u_address (
		.clk_sys(clk_sys), .reset(reset), .i_detach(i_detach),
		.i_kind(kind), .i_wr(dec_wr), .i_addr(dec_addr), .i_data(dec_data),
		.i_start(dec_start), .i_end(dec_end), .i_active(dec_active),
		.i_ct_base(ct_base),
		.o_wr(adr_wr), .o_addr(adr_addr), .o_data(adr_data),
		.o_prg_done(prg_done), .o_end_addr(end_addr),
		.o_cart_blk(o_cart_blk), .o_cart_reset(o_cart_reset),
		.o_mc_loaded(o_mc_loaded)
	);

	basic_fixup u_fixup (
		.clk_sys(clk_sys), .reset(reset),
		.i_wr(adr_wr), .i_addr(adr_addr), .i_data(adr_data),
		.i_prg_done(prg_done), .i_end_addr(end_addr),
		.o_dl_wr(o_dl_wr), .o_dl_addr(o_dl_addr), .o_dl_data(o_dl_data)
	);

endmodule

/* dv/loader_tb.sv */
/*
 * loader testbench
 * table of download jobs against a reference write list and flag levels
 */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module loader_tb import loader_pkg::*; ();

	logic clk_sys, reset;
	logic i_ioctl_download, i_ioctl_wr, i_detach;
	logic [7:0] i_ioctl_index, i_ext_char;
	logic [`LDR_IOCTL_AW-1:0] i_ioctl_addr;
	logic [`LDR_DW-1:0] i_ioctl_dout;
	logic o_dl_wr, o_cart_reset, o_mc_loaded;
	logic [`LDR_AW-1:0] o_dl_addr;
	logic [`LDR_DW-1:0] o_dl_data;
	logic [`LDR_NBLK-1:0] o_cart_blk;

	// one row per download job
	typedef struct {
		logic [7:0] index;
		logic [7:0] ext;
		int first;
		int count;
		logic [15:0] hdr;
		bit detach;
		logic [4:0] exp_blk;
		bit exp_crst;
		bit exp_mc;
	} job_t;

	job_t jobs[$];
	// writes as {addr, data} keyed by arrival order
	logic [23:0] exp_wr [int];
	logic [23:0] got_wr [int];
	int exp_n, got_n, errors, checks;
	int limit_cycles = 0;
	logic [31:0] lcg_state;
	logic [15:0] ptr_tab [8] = '{16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF};

	loader_top DUT (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	// collect every memory write at the falling edge where outputs are stable
	always @(negedge clk_sys) begin
		if (o_dl_wr === 1'b1) begin
			got_wr[got_n] = {o_dl_addr, o_dl_data};
			got_n++;
		end
	end

	////////////////////
	// reference model
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// exact indices first, then megacart on low five bits
	function automatic load_kind_t kind_of(input logic [7:0] idx);
		case (idx)
			8'h01: return LOAD_PRG;
			8'h41: return LOAD_CRT;
			8'h81: return LOAD_CT;
			8'h06: return LOAD_ROM;
			default: return (idx[4:0] == 5'd2) ? LOAD_MC : LOAD_NONE;
		endcase
	endfunction

	// raw cart start from the last extension character
	function automatic logic [15:0] ct_start(input logic [7:0] c);
		if (c >= "2" && c <= "9")
			return 16'(c[3:0]) * 16'h1000;
		if (c == "A" || c == "B")
			return (16'(c[3:0]) + 16'd9) * 16'h1000;
		return 16'h0000;
	endfunction

	function automatic void expect_write(input logic [15:0] a, input logic [7:0] d);
		exp_wr[exp_n] = {a, d};
		exp_n++;
	endfunction

	task automatic add_job(input logic [7:0] index, input logic [7:0] ext, input int first,
		input int count, input logic [15:0] hdr, input bit detach,
		input logic [4:0] blk, input bit crst, input bit mc);
		job_t j;
		j = '{index, ext, first, count, hdr, detach, blk, crst, mc};
		jobs.push_back(j);
	endtask

	task automatic check_level(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// count first and then every pair in order
	task automatic compare_writes();
		checks++;
		assert (got_n == exp_n) else begin
			$display("FAILED t=%0t o_dl_wr count got %0d expected %0d", $time, got_n, exp_n);
			errors++;
		end
		for (int i = 0; i < exp_n && i < got_n; i++) begin
			checks++;
			assert (got_wr[i] === exp_wr[i]) else begin
				$display("FAILED t=%0t o_dl_addr/o_dl_data got %h/%h expected %h/%h",
					$time, got_wr[i][23:8], got_wr[i][7:0], exp_wr[i][23:8], exp_wr[i][7:0]);
				errors++;
			end
		end
	endtask

	////////////////////
	// job driver
	////////////////////

	task automatic run_job(input job_t j);
		load_kind_t k;
		logic [15:0] run, limit, off;
		logic [7:0] d;
		bit hdr_kind;
		k = kind_of(j.index);
		hdr_kind = (k == LOAD_PRG) || (k == LOAD_CRT);
		run = (k == LOAD_CT) ? ct_start(j.ext) : j.hdr;
		limit = (k == LOAD_PRG) ? 16'hA000 : 16'hC000;
		exp_wr.delete();
		got_wr.delete();
		exp_n = 0;
		got_n = 0;
		@(negedge clk_sys);
		i_ioctl_index = j.index;
		i_ext_char = j.ext;
		@(negedge clk_sys);
		i_ioctl_download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (int i = 0; i < j.count; i++) begin
			off = 16'(j.first + i);
			lcg_state = lcg_next(lcg_state);
			d = lcg_state[23:16];
			// header address goes out as host bytes 0 and 1
			if (hdr_kind && off == 16'd0)
				d = j.hdr[7:0];
			if (hdr_kind && off == 16'd1)
				d = j.hdr[15:8];
			i_ioctl_wr = 1'b1;
			i_ioctl_addr = `LDR_IOCTL_AW'(j.first + i);
			i_ioctl_dout = d;
			@(negedge clk_sys);
			i_ioctl_wr = 1'b0;
			@(negedge clk_sys);
			if (hdr_kind && off > 16'd1 && run < limit) begin
				expect_write(run, d);
				run = run + 16'd1;
			end else if (k == LOAD_CT && run < 16'hC000) begin
				expect_write(run, d);
				run = run + 16'd1;
			end else if (k == LOAD_ROM && off >= 16'h4000 && off < 16'h8000) begin
				expect_write(off + 16'h8000, d);
			end
		end
		repeat (3) @(negedge clk_sys);
		// cart kinds hold the machine in reset while loading
		check_level("o_cart_reset", 8'(o_cart_reset),
			8'((k == LOAD_CRT) || (k == LOAD_CT) || (k == LOAD_MC)));
		i_ioctl_download = 1'b0;
		if (k == LOAD_PRG) begin
			for (int p = 0; p < 8; p++)
				expect_write(ptr_tab[p], p[0] ? run[15:8] : run[7:0]);
		end
		repeat (24) @(negedge clk_sys);
		compare_writes();
		checks++;
		assert (DUT.u_fixup.state == FIX_IDLE) else begin
			$display("error t=%0t pointer fixup FSM has not returned to idle", $time);
			errors++;
		end
		if (j.detach) begin
			i_detach = 1'b1;
			@(negedge clk_sys);
			i_detach = 1'b0;
			repeat (6) @(negedge clk_sys);
		end
		check_level("o_cart_blk", 8'(o_cart_blk), 8'(j.exp_blk));
		check_level("o_cart_reset", 8'(o_cart_reset), 8'(j.exp_crst));
		check_level("o_mc_loaded", 8'(o_mc_loaded), 8'(j.exp_mc));
	endtask

	////////////////////
	// main
	////////////////////

	initial begin
		errors = 0;
		checks = 0;
		lcg_state = 32'hb5b0_7abd;
		reset = 1'b1;
		i_ioctl_download = 1'b0;
		i_ioctl_index = 8'h00;
		i_ioctl_wr = 1'b0;
		i_ioctl_addr = '0;
		i_ioctl_dout = 8'h00;
		i_ext_char = 8'h00;
		i_detach = 1'b0;
		// index, ext, first offset, count, header, detach, blk, cart reset, megacart
		add_job(8'h01, 8'h00, 0, 32, 16'h0801, 0, 5'b00000, 0, 0);
		add_job(8'h01, 8'h00, 0, 40, 16'h9FF0, 0, 5'b00000, 0, 0);
		add_job(8'h06, 8'h00, 'h3FFC, 8, 16'h0000, 0, 5'b00000, 0, 0);
		add_job(8'h06, 8'h00, 'h7FFE, 4, 16'h0000, 0, 5'b00000, 0, 0);
		add_job(8'h41, 8'h00, 0, 20, 16'h7FF8, 0, 5'b01000, 0, 0);
		add_job(8'h41, 8'h00, 0, 24, 16'hBFF0, 0, 5'b11000, 0, 0);
		add_job(8'h81, "2", 0, 16, 16'h0000, 0, 5'b11010, 0, 0);
		add_job(8'h81, "A", 0, 16, 16'h0000, 0, 5'b11010, 0, 0);
		add_job(8'h81, "X", 0, 8, 16'h0000, 0, 5'b11011, 0, 0);
		add_job(8'h42, 8'h00, 0, 8, 16'h0000, 0, 5'b00000, 0, 1);
		add_job(8'h41, 8'h00, 0, 6, 16'h6000, 0, 5'b01000, 0, 0);
		// tape index decodes as no load
		add_job(8'hC1, 8'h00, 0, 8, 16'h0000, 0, 5'b01000, 0, 0);
		add_job(8'h81, "B", 0, 4, 16'h0000, 1, 5'b00000, 0, 0);
		add_job(8'h42, 8'h00, 0, 4, 16'h0000, 1, 5'b00000, 0, 0);
		foreach (jobs[r])
			limit_cycles += jobs[r].count * 4 + 100;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		foreach (jobs[r])
			run_job(jobs[r]);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// watchdog sized from the job table
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("watchdog: run did not finish within %0d cycles", limit_cycles);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
common/loader_pkg.sv
loader/load_decode.sv
loader/load_address.sv
loader/basic_fixup.sv
loader/loader_top.sv
dv/loader_tb.sv

/* Makefile */
TOP = loader_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
